// File: common/fp_i2f_pkg.sv
//////////////////////////////
// integer to float conversion package
// format widths, bias, rounding-mode codes and the
// vector types shared by both pipeline stages
//////////////////////////////

package fp_i2f_pkg;

  // integer operand and float format
  localparam int XLEN       = 32;
  localparam int FRAC_WIDTH = 23;
  localparam int EXPO_WIDTH = 8;
  localparam int FLEN       = 32;
  localparam int BIAS       = 127;

  // magnitude bits that fall below the fraction field
  localparam int TAIL_WIDTH = XLEN - FRAC_WIDTH;

  // request tag width
  localparam int ID_WIDTH = 3;

  // riscv rounding modes (frm encoding)
  localparam logic [2:0] RM_RNE = 3'd0;
  localparam logic [2:0] RM_RTZ = 3'd1;
  localparam logic [2:0] RM_RDN = 3'd2;
  localparam logic [2:0] RM_RUP = 3'd3;
  localparam logic [2:0] RM_RMM = 3'd4;

  // inexact bit in fflags {nv, dz, of, uf, nx}
  localparam int FLAG_NX = 0;

  //////////////////////////////
  // vector types
  //////////////////////////////
  typedef logic [XLEN-1:0]       int_word_t;
  typedef logic [FLEN-1:0]       fp_word_t;
  typedef logic [EXPO_WIDTH-1:0] expo_t;
  typedef logic [FRAC_WIDTH-1:0] frac_t;
  typedef logic [TAIL_WIDTH-1:0] tail_t;
  typedef logic [4:0]            shift_amt_t;
  typedef logic [2:0]            rm_t;
  typedef logic [4:0]            fflags_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

endpackage

// File: fp_i2f/clz.sv
//////////////////////////////
// leading zero counter
// binary priority tree over a 32-bit magnitude
//////////////////////////////

`timescale 1ns/1ps

module clz import fp_i2f_pkg::*; (
  input  int_word_t  clz_input,
  output shift_amt_t clz
);

  // each level halves the window that can hold the first one
  logic [31:0] lvl16;
  logic [31:0] lvl8;
  logic [31:0] lvl4;
  logic [31:0] lvl2;

  // upper half empty, count 16 and move the low half up
  assign clz[4] = ~|clz_input[31:16];
  assign lvl16  = clz[4] ? {clz_input[15:0], 16'b0} : clz_input;

  assign clz[3] = ~|lvl16[31:24];
  assign lvl8   = clz[3] ? {lvl16[23:0], 8'b0} : lvl16;

  assign clz[2] = ~|lvl8[31:28];
  assign lvl4   = clz[2] ? {lvl8[27:0], 4'b0} : lvl8;

  assign clz[1] = ~|lvl4[31:30];
  assign lvl2   = clz[1] ? {lvl4[29:0], 2'b0} : lvl4;

  // last bit decides between 0 and 1 more zero
  // only bit 0 set lands here with 31
  // an all zero input also yields 31 and fp_i2f masks it with zero
  assign clz[0] = ~lvl2[31];

endmodule

// File: fp_i2f/fp_i2f.sv
//////////////////////////////
// int to float first stage
// sign, magnitude and zero detect, stage register,
// then prenormalized fields and leading zero count
//////////////////////////////

`timescale 1ns/1ps

module fp_i2f import fp_i2f_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  logic       new_request,
  input  id_t        id,
  input  int_word_t  rs1,
  input  logic       is_signed,
  input  rm_t        rm,
  output logic       stage1_done,
  output id_t        stage1_id,
  output logic       sign,
  output logic       zero,
  output expo_t      prenorm_expo,
  output frac_t      prenorm_frac,
  output tail_t      tail,
  output shift_amt_t clz_count,
  output rm_t        stage1_rm
);

  int_word_t neg_rs1;
  int_word_t abs_in;
  logic      sign_in;
  logic      zero_in;

  // stage register contents
  int_word_t abs_r;

  //////////////////////////////
  // absolute value
  //////////////////////////////
  assign neg_rs1 = -rs1;

  always_comb begin
    // negative only when signed and msb set
    if (is_signed && rs1[XLEN-1]) begin
      sign_in = 1'b1;
      abs_in  = neg_rs1;
    end else begin
      sign_in = 1'b0;
      abs_in  = rs1;
    end
  end

  assign zero_in = ~|rs1;

  //////////////////////////////
  // stage register
  //////////////////////////////
  // everything holds while advance is low
  always_ff @(posedge clk) begin
    if (rst) begin
      stage1_done <= 1'b0;
    end else if (advance) begin
      stage1_done <= new_request;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (advance) begin
      abs_r     <= abs_in;
      sign      <= sign_in;
      zero      <= zero_in;
      stage1_rm <= rm;
      stage1_id <= id;
    end
  end

  //////////////////////////////
  // prenormalized result
  //////////////////////////////
  // value read as frac with binary point below bit 0
  // 0x80000000 signed stays 0x80000000, exact as unsigned
  assign prenorm_frac = abs_r[XLEN-1 -: FRAC_WIDTH];
  assign tail         = abs_r[TAIL_WIDTH-1:0];

  // exponent 150 before the shift, forced to 0 for zero
  assign prenorm_expo = zero ? '0 : expo_t'(FRAC_WIDTH + BIAS);

  clz clz_inst (
    .clz_input (abs_r),
    .clz       (clz_count)
  );

endmodule

// File: src/fp_normalize_round.sv
//////////////////////////////
// int to float second stage
// normalizing shift, rounding by mode,
// exponent fix-up and packing of the result
//////////////////////////////

`timescale 1ns/1ps

module fp_normalize_round import fp_i2f_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       advance,
  input  logic       stage1_done,
  input  id_t        stage1_id,
  input  logic       sign,
  input  logic       zero,
  input  expo_t      prenorm_expo,
  input  frac_t      prenorm_frac,
  input  tail_t      tail,
  input  shift_amt_t clz_count,
  input  rm_t        stage1_rm,
  output logic       done,
  output id_t        done_id,
  output fp_word_t   rd,
  output fflags_t    fflags
);

  int_word_t        magnitude;
  logic [5:0]       shift_amt;
  int_word_t        shifted;
  frac_t            mant;
  logic             guard;
  logic             sticky;
  logic             inexact;
  logic             round_up;
  logic [FRAC_WIDTH:0] mant_sum;
  expo_t            expo_norm;
  expo_t            expo_final;
  fp_word_t         rd_next;
  fflags_t          fflags_next;

  //////////////////////////////
  // normalize
  //////////////////////////////
  assign magnitude = {prenorm_frac, tail};

  // one past the leading zeros drops the implicit bit off the top
  // 6 bits so that clz 31 gives a shift of 32
  assign shift_amt = {1'b0, clz_count} + 6'd1;
  assign shifted   = magnitude << shift_amt;

  assign mant   = shifted[XLEN-1 -: FRAC_WIDTH];
  assign guard  = shifted[TAIL_WIDTH-1];
  assign sticky = |shifted[TAIL_WIDTH-2:0];

  // 150 + 8 - clz, same as bias + 31 - clz
  assign expo_norm = prenorm_expo + expo_t'(TAIL_WIDTH - 1) - expo_t'(clz_count);

  //////////////////////////////
  // round
  //////////////////////////////
  assign inexact = guard | sticky;

  always_comb begin
    case (stage1_rm)
      // ties go to even mantissa
      RM_RNE:  round_up = guard & (sticky | mant[0]);
      RM_RTZ:  round_up = 1'b0;
      // toward -inf, bigger magnitude for negatives
      RM_RDN:  round_up = sign & inexact;
      RM_RUP:  round_up = ~sign & inexact;
      // ties away from zero
      RM_RMM:  round_up = guard;
      default: round_up = 1'b0;
    endcase
  end

  // carry out means mantissa wrapped to 0, bump exponent
  assign mant_sum   = {1'b0, mant} + {{FRAC_WIDTH{1'b0}}, round_up};
  assign expo_final = expo_norm + expo_t'(mant_sum[FRAC_WIDTH]);

  //////////////////////////////
  // pack
  //////////////////////////////
  always_comb begin
    rd_next     = {sign, expo_final, mant_sum[FRAC_WIDTH-1:0]};
    fflags_next = '0;
    fflags_next[FLAG_NX] = inexact;
    // zero operand is +0, exact
    if (zero) begin
      rd_next     = '0;
      fflags_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else if (advance) begin
      done <= stage1_done;
    end
  end

  // result registers hold with done while stalled
  always_ff @(posedge clk) begin
    if (advance) begin
      done_id <= stage1_id;
      rd      <= rd_next;
      fflags  <= fflags_next;
    end
  end

endmodule

// File: src/fp_i2f_unit.sv
//////////////////////////////
// int to float conversion unit
// two stage pipeline, single precision result
//////////////////////////////

`timescale 1ns/1ps

module fp_i2f_unit import fp_i2f_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      advance,
  input  logic      new_request,
  input  id_t       id,
  input  int_word_t rs1,
  input  logic      is_signed,
  input  rm_t       rm,
  output logic      done,
  output id_t       done_id,
  output fp_word_t  rd,
  output fflags_t   fflags
);

  // stage 1 to stage 2
  logic       stage1_done;
  id_t        stage1_id;
  logic       sign;
  logic       zero;
  expo_t      prenorm_expo;
  frac_t      prenorm_frac;
  tail_t      tail;
  shift_amt_t clz_count;
  rm_t        stage1_rm;

  // abs, zero detect, register, prenormalize
  fp_i2f i2f_inst (
    .clk          (clk),
    .rst          (rst),
    .advance      (advance),
    .new_request  (new_request),
    .id           (id),
    .rs1          (rs1),
    .is_signed    (is_signed),
    .rm           (rm),
    .stage1_done  (stage1_done),
    .stage1_id    (stage1_id),
    .sign         (sign),
    .zero         (zero),
    .prenorm_expo (prenorm_expo),
    .prenorm_frac (prenorm_frac),
    .tail         (tail),
    .clz_count    (clz_count),
    .stage1_rm    (stage1_rm)
  );

  // shift, round, pack
  fp_normalize_round norm_round_inst (
    .clk          (clk),
    .rst          (rst),
    .advance      (advance),
    .stage1_done  (stage1_done),
    .stage1_id    (stage1_id),
    .sign         (sign),
    .zero         (zero),
    .prenorm_expo (prenorm_expo),
    .prenorm_frac (prenorm_frac),
    .tail         (tail),
    .clz_count    (clz_count),
    .stage1_rm    (stage1_rm),
    .done         (done),
    .done_id      (done_id),
    .rd           (rd),
    .fflags       (fflags)
  );

endmodule

// File: sim/fp_i2f_unit_tb.sv
//////////////////////////////
// int to float unit testbench
// table of operands and expected floats, random stalls,
// in-order result and tag checking
//////////////////////////////

`timescale 1ns/1ps

module fp_i2f_unit_tb import fp_i2f_pkg::*; ();

  localparam int RESET_CYCLES = 16;

  logic      clk;
  logic      rst;
  logic      advance;
  logic      new_request;
  id_t       id;
  int_word_t rs1;
  logic      is_signed;
  rm_t       rm;
  logic      done;
  id_t       done_id;
  fp_word_t  rd;
  fflags_t   fflags;

  // test table, one entry per index
  string     name_q[$];
  int_word_t rs1_q[$];
  logic      signed_q[$];
  rm_t       rm_q[$];
  fp_word_t  rd_q[$];
  logic      nx_q[$];

  // table indices issued and not yet seen at the output
  int        exp_q[$];
  int        checked;
  bit        table_ready;

  fp_i2f_unit uut (
    .clk         (clk),
    .rst         (rst),
    .advance     (advance),
    .new_request (new_request),
    .id          (id),
    .rs1         (rs1),
    .is_signed   (is_signed),
    .rm          (rm),
    .done        (done),
    .done_id     (done_id),
    .rd          (rd),
    .fflags      (fflags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_test(input string name, input int_word_t val, input logic sgn,
                          input rm_t mode, input fp_word_t exp_rd, input logic exp_nx);
    name_q.push_back(name);
    rs1_q.push_back(val);
    signed_q.push_back(sgn);
    rm_q.push_back(mode);
    rd_q.push_back(exp_rd);
    nx_q.push_back(exp_nx);
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////
  initial begin
    wait (table_ready);
    repeat (rd_q.size() * 20 + RESET_CYCLES) @(posedge clk);
    stop_on_error("timeout: not all results came out of the unit in time");
  end

  //////////////////////////////
  // result checker
  //////////////////////////////
  // a held done is consumed only on an edge with advance high
  always @(posedge clk) begin : result_check
    int       idx;
    fflags_t  exp_flags;
    if (!rst && done) begin
      assert (exp_q.size() > 0)
        else stop_on_error("done is high with no request outstanding");
      if (advance) begin
        idx       = exp_q.pop_front();
        exp_flags = '0;
        exp_flags[FLAG_NX] = nx_q[idx];
        assert (done_id == id_t'(idx % 8))
          else stop_on_error($sformatf("[FAIL] %s: expected tag %0d, actual %0d",
                                       name_q[idx], idx % 8, done_id));
        assert (rd == rd_q[idx])
          else stop_on_error($sformatf("[FAIL] %s: expected rd %h, actual %h",
                                       name_q[idx], rd_q[idx], rd));
        assert (fflags == exp_flags)
          else stop_on_error($sformatf("[FAIL] %s: expected fflags %b, actual %b",
                                       name_q[idx], exp_flags, fflags));
        checked++;
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    logic adv;
    rst         = 1'b1;
    advance     = 1'b0;
    new_request = 1'b0;
    id          = '0;
    rs1         = '0;
    is_signed   = 1'b0;
    rm          = RM_RNE;
    checked     = 0;
    table_ready = 1'b0;
    void'($urandom(32'hd8b8));

    // zero in any mode is +0, exact
    add_test("zero_unsigned_rne", 32'h00000000, 1'b0, RM_RNE, 32'h00000000, 1'b0);
    add_test("zero_signed_rdn",   32'h00000000, 1'b1, RM_RDN, 32'h00000000, 1'b0);
    add_test("zero_signed_rup",   32'h00000000, 1'b1, RM_RUP, 32'h00000000, 1'b0);
    // exactly representable
    add_test("one_unsigned",      32'h00000001, 1'b0, RM_RNE, 32'h3F800000, 1'b0);
    add_test("minus_one_signed",  32'hFFFFFFFF, 1'b1, RM_RUP, 32'hBF800000, 1'b0);
    add_test("val_12345",         32'h00003039, 1'b1, RM_RDN, 32'h4640E400, 1'b0);
    add_test("two_pow_24",        32'h01000000, 1'b0, RM_RNE, 32'h4B800000, 1'b0);
    add_test("int_min_signed",    32'h80000000, 1'b1, RM_RNE, 32'hCF000000, 1'b0);
    add_test("two_pow_31",        32'h80000000, 1'b0, RM_RMM, 32'h4F000000, 1'b0);
    add_test("max_24_bits",       32'h00FFFFFF, 1'b0, RM_RUP, 32'h4B7FFFFF, 1'b0);
    // 2^24+1, halfway, even neighbour below
    add_test("p_1000001_rne",     32'h01000001, 1'b0, RM_RNE, 32'h4B800000, 1'b1);
    add_test("p_1000001_rtz",     32'h01000001, 1'b0, RM_RTZ, 32'h4B800000, 1'b1);
    add_test("p_1000001_rdn",     32'h01000001, 1'b0, RM_RDN, 32'h4B800000, 1'b1);
    add_test("p_1000001_rup",     32'h01000001, 1'b0, RM_RUP, 32'h4B800001, 1'b1);
    add_test("p_1000001_rmm",     32'h01000001, 1'b0, RM_RMM, 32'h4B800001, 1'b1);
    add_test("n_1000001_rne",     32'hFEFFFFFF, 1'b1, RM_RNE, 32'hCB800000, 1'b1);
    add_test("n_1000001_rtz",     32'hFEFFFFFF, 1'b1, RM_RTZ, 32'hCB800000, 1'b1);
    add_test("n_1000001_rdn",     32'hFEFFFFFF, 1'b1, RM_RDN, 32'hCB800001, 1'b1);
    add_test("n_1000001_rup",     32'hFEFFFFFF, 1'b1, RM_RUP, 32'hCB800000, 1'b1);
    add_test("n_1000001_rmm",     32'hFEFFFFFF, 1'b1, RM_RMM, 32'hCB800001, 1'b1);
    // 2^24+3, halfway, even neighbour above
    add_test("p_1000003_rne",     32'h01000003, 1'b0, RM_RNE, 32'h4B800002, 1'b1);
    add_test("p_1000003_rtz",     32'h01000003, 1'b0, RM_RTZ, 32'h4B800001, 1'b1);
    add_test("p_1000003_rdn",     32'h01000003, 1'b0, RM_RDN, 32'h4B800001, 1'b1);
    add_test("p_1000003_rup",     32'h01000003, 1'b0, RM_RUP, 32'h4B800002, 1'b1);
    add_test("p_1000003_rmm",     32'h01000003, 1'b0, RM_RMM, 32'h4B800002, 1'b1);
    add_test("n_1000003_rne",     32'hFEFFFFFD, 1'b1, RM_RNE, 32'hCB800002, 1'b1);
    add_test("n_1000003_rtz",     32'hFEFFFFFD, 1'b1, RM_RTZ, 32'hCB800001, 1'b1);
    add_test("n_1000003_rdn",     32'hFEFFFFFD, 1'b1, RM_RDN, 32'hCB800002, 1'b1);
    add_test("n_1000003_rup",     32'hFEFFFFFD, 1'b1, RM_RUP, 32'hCB800001, 1'b1);
    add_test("n_1000003_rmm",     32'hFEFFFFFD, 1'b1, RM_RMM, 32'hCB800002, 1'b1);
    // 2^31-1, just below a power of two
    add_test("p_7fffffff_rne",    32'h7FFFFFFF, 1'b1, RM_RNE, 32'h4F000000, 1'b1);
    add_test("p_7fffffff_rtz",    32'h7FFFFFFF, 1'b1, RM_RTZ, 32'h4EFFFFFF, 1'b1);
    add_test("p_7fffffff_rdn",    32'h7FFFFFFF, 1'b1, RM_RDN, 32'h4EFFFFFF, 1'b1);
    add_test("p_7fffffff_rup",    32'h7FFFFFFF, 1'b1, RM_RUP, 32'h4F000000, 1'b1);
    add_test("p_7fffffff_rmm",    32'h7FFFFFFF, 1'b1, RM_RMM, 32'h4F000000, 1'b1);
    add_test("n_7fffffff_rne",    32'h80000001, 1'b1, RM_RNE, 32'hCF000000, 1'b1);
    add_test("n_7fffffff_rtz",    32'h80000001, 1'b1, RM_RTZ, 32'hCEFFFFFF, 1'b1);
    add_test("n_7fffffff_rdn",    32'h80000001, 1'b1, RM_RDN, 32'hCF000000, 1'b1);
    add_test("n_7fffffff_rup",    32'h80000001, 1'b1, RM_RUP, 32'hCEFFFFFF, 1'b1);
    add_test("n_7fffffff_rmm",    32'h80000001, 1'b1, RM_RMM, 32'hCF000000, 1'b1);
    // mantissa carry into the exponent
    add_test("max_unsigned_rne",  32'hFFFFFFFF, 1'b0, RM_RNE, 32'h4F800000, 1'b1);
    add_test("max_unsigned_rtz",  32'hFFFFFFFF, 1'b0, RM_RTZ, 32'h4F7FFFFF, 1'b1);
    add_test("max_as_signed_rne", 32'hFFFFFFFF, 1'b1, RM_RNE, 32'hBF800000, 1'b0);
    // guard and sticky both set
    add_test("p_2000003_rne",     32'h02000003, 1'b0, RM_RNE, 32'h4C000001, 1'b1);
    add_test("p_2000003_rtz",     32'h02000003, 1'b0, RM_RTZ, 32'h4C000000, 1'b1);
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // idle with stalls, done has to stay low
    repeat (6) begin
      advance <= ($urandom % 2) != 0;
      @(posedge clk);
    end

    // back to back issue, a stall cycle drives junk operands
    for (int i = 0; i < rd_q.size(); i++) begin
      do begin
        adv = ($urandom % 4) != 0;
        advance     <= adv;
        new_request <= 1'b1;
        id          <= id_t'(i % 8);
        rs1         <= adv ? rs1_q[i] : int_word_t'($urandom);
        is_signed   <= signed_q[i];
        rm          <= rm_q[i];
        @(posedge clk);
      end while (!adv);
      exp_q.push_back(i);
    end
    new_request <= 1'b0;

    // drain with stalls
    while (exp_q.size() > 0) begin
      advance <= ($urandom % 4) != 0;
      @(posedge clk);
    end

    // extra cycles catch a repeated done
    advance <= 1'b1;
    repeat (8) @(posedge clk);

    if (checked == rd_q.size()) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("only %0d of %0d results came out", checked, rd_q.size());
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: fp_i2f_unit.f
common/fp_i2f_pkg.sv
fp_i2f/clz.sv
fp_i2f/fp_i2f.sv
src/fp_normalize_round.sv
src/fp_i2f_unit.sv
sim/fp_i2f_unit_tb.sv

// File: Makefile
# Verilator build for the int to float unit testbench

VERILATOR ?= verilator
TOP       ?= fp_i2f_unit_tb
FILELIST  ?= fp_i2f_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
